// File: lcd_pkg.sv
package lcd_pkg;

	// one byte, seen as a character or as the two nibbles sent on the bus
	typedef union packed {
		logic [7:0] chr;
		struct packed {
			logic [3:0] hi;
			logic [3:0] lo;
		} nib;
	} lcd_byte_u;

	// HD44780 command bytes, 4-bit bus
	localparam logic [7:0] cmd_function_set = 8'h28; // 4-bit, 2 lines, 5x8
	localparam logic [7:0] cmd_entry_mode = 8'h06; // increment, no shift
	localparam logic [7:0] cmd_display_on = 8'h0C; // display on, cursor off
	localparam logic [7:0] cmd_clear = 8'h01;
	localparam logic [7:0] cmd_line1_addr = 8'h80;
	localparam logic [7:0] cmd_line2_addr = 8'hC0;

	// wake-up nibbles
	localparam logic [3:0] wake_nibble_a = 4'h3;
	localparam logic [3:0] wake_nibble_b = 4'h2;

	localparam int msg_len = 32;
	localparam int line_len = 16;

	// byte addresses of the register map
	localparam logic [7:0] addr_char_base = 8'h00;
	localparam logic [7:0] addr_ctrl = 8'h80;
	localparam logic [7:0] addr_status = 8'h84;

endpackage

// File: lcd_msg_ram.sv
`timescale 1ns/1ps

module lcd_msg_ram (
	input  logic       clk,
	input  logic       reset,
	input  logic       we,
	input  logic [4:0] waddr,
	input  logic [7:0] wdata,
	input  logic [4:0] raddr_a,
	output logic [7:0] rdata_a,
	input  logic [4:0] raddr_b,
	output logic [7:0] rdata_b
);
	import lcd_pkg::*;

	localparam logic [7:0] blank = 8'h20; // ascii space

	logic [7:0] mem [msg_len];

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			for (int i = 0; i < msg_len; i++) begin
				mem[i] <= blank;
			end
		end else if (we) begin
			mem[waddr] <= wdata;
		end
	end

	// port a for the host, port b for the refresh engine
	assign rdata_a = mem[raddr_a];
	assign rdata_b = mem[raddr_b];

endmodule

// File: lcd_nibble_tx.sv
`timescale 1ns/1ps

module lcd_nibble_tx #(
	parameter int unsigned setup_cycles = 2,
	parameter int unsigned en_cycles = 4,
	parameter int unsigned nibble_gap = 2,
	parameter int unsigned cmd_wait = 10,
	parameter int unsigned clear_wait = 40
) (
	input  logic              clk,
	input  logic              reset,
	input  logic              start,
	input  lcd_pkg::lcd_byte_u byte_in,
	input  logic              rs,
	input  logic              nibble_only,
	output logic              lcd_en,
	output logic              lcd_rs,
	output logic [3:0]        lcd_d,
	output logic              done
);
	import lcd_pkg::*;

	localparam logic [2:0] s_idle = 3'd0;
	localparam logic [2:0] s_setup = 3'd1;
	localparam logic [2:0] s_en = 3'd2;
	localparam logic [2:0] s_gap = 3'd3;
	localparam logic [2:0] s_wait = 3'd4;

	logic [2:0] state;
	logic [31:0] cnt;
	logic low_phase; // second nibble of a full byte in flight
	logic nibble_only_q;
	lcd_byte_u byte_q;
	logic [31:0] wait_len;

	// clear needs the long settle time
	assign wait_len = (byte_q.chr == cmd_clear) ? clear_wait : cmd_wait;

	always_ff @(posedge clk) begin
		if (start && state == s_idle) begin
			byte_q <= byte_in;
			nibble_only_q <= nibble_only;
		end
	end

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			state <= s_idle;
			cnt <= '0;
			low_phase <= 1'b0;
			lcd_en <= 1'b0;
			lcd_rs <= 1'b0;
			lcd_d <= '0;
			done <= 1'b0;
		end else begin
			done <= 1'b0;
			case (state)
				s_idle: begin
					if (start) begin
						lcd_d <= byte_in.nib.hi; // upper nibble goes first
						lcd_rs <= rs;
						low_phase <= 1'b0;
						cnt <= '0;
						state <= s_setup;
					end
				end
				s_setup: begin
					if (cnt + 32'd1 >= setup_cycles) begin
						cnt <= '0;
						lcd_en <= 1'b1;
						state <= s_en;
					end else begin
						cnt <= cnt + 32'd1;
					end
				end
				s_en: begin
					if (cnt + 32'd1 >= en_cycles) begin
						cnt <= '0;
						lcd_en <= 1'b0; // data latched on this falling edge
						state <= (low_phase || nibble_only_q) ? s_wait : s_gap;
					end else begin
						cnt <= cnt + 32'd1;
					end
				end
				s_gap: begin
					if (cnt + 32'd1 >= nibble_gap) begin
						cnt <= '0;
						lcd_d <= byte_q.nib.lo;
						low_phase <= 1'b1;
						state <= s_setup;
					end else begin
						cnt <= cnt + 32'd1;
					end
				end
				s_wait: begin
					if (cnt + 32'd1 >= wait_len) begin
						cnt <= '0;
						done <= 1'b1;
						state <= s_idle;
					end else begin
						cnt <= cnt + 32'd1;
					end
				end
				default: state <= s_idle;
			endcase
		end
	end

endmodule

// File: lcd_control.sv
`timescale 1ns/1ps

module lcd_control #(
	parameter int unsigned powerup_cycles = 100
) (
	input  logic       clk,
	input  logic       reset,
	input  logic       display_enable,
	input  logic       tx_done,
	input  logic [7:0] rd_data_b,
	output logic [4:0] rd_addr_b,
	output logic       tx_start,
	output logic [7:0] tx_byte,
	output logic       tx_rs,
	output logic       tx_nibble_only,
	output logic       init_done
);
	import lcd_pkg::*;

	localparam logic [2:0] s_power = 3'd0;
	localparam logic [2:0] s_wake = 3'd1;
	localparam logic [2:0] s_init = 3'd2;
	localparam logic [2:0] s_idle = 3'd3;
	localparam logic [2:0] s_addr1 = 3'd4;
	localparam logic [2:0] s_line1 = 3'd5;
	localparam logic [2:0] s_addr2 = 3'd6;
	localparam logic [2:0] s_line2 = 3'd7;

	logic [2:0] state;
	logic [4:0] idx; // wake/init step, or buffer index during refresh
	logic [31:0] pwr_cnt;
	logic pending; // transfer started, waiting for done
	logic [7:0] next_byte;
	logic next_rs;
	logic next_nib;

	assign rd_addr_b = idx;

	always_comb begin
		next_byte = rd_data_b;
		next_rs = 1'b1;
		next_nib = 1'b0;
		case (state)
			s_wake: begin
				next_byte = {(idx[1:0] == 2'd3) ? wake_nibble_b : wake_nibble_a, 4'h0};
				next_rs = 1'b0;
				next_nib = 1'b1;
			end
			s_init: begin
				next_rs = 1'b0;
				case (idx[1:0])
					2'd0: next_byte = cmd_function_set;
					2'd1: next_byte = cmd_entry_mode;
					2'd2: next_byte = cmd_display_on;
					default: next_byte = cmd_clear;
				endcase
			end
			s_addr1: begin
				next_byte = cmd_line1_addr;
				next_rs = 1'b0;
			end
			s_addr2: begin
				next_byte = cmd_line2_addr;
				next_rs = 1'b0;
			end
			default: ; // characters straight from the buffer
		endcase
	end

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			state <= s_power;
			idx <= '0;
			pwr_cnt <= '0;
			pending <= 1'b0;
			tx_start <= 1'b0;
			tx_byte <= '0;
			tx_rs <= 1'b0;
			tx_nibble_only <= 1'b0;
			init_done <= 1'b0;
		end else begin
			tx_start <= 1'b0;
			case (state)
				s_power: begin
					if (pwr_cnt + 32'd1 >= powerup_cycles) begin
						idx <= '0;
						state <= s_wake;
					end else begin
						pwr_cnt <= pwr_cnt + 32'd1;
					end
				end
				s_idle: begin
					if (display_enable) begin
						idx <= '0;
						state <= s_addr1;
					end
				end
				default: begin
					if (!pending) begin
						tx_start <= 1'b1;
						tx_byte <= next_byte;
						tx_rs <= next_rs;
						tx_nibble_only <= next_nib;
						pending <= 1'b1;
					end else if (tx_done) begin
						pending <= 1'b0;
						case (state)
							s_wake: begin
								idx <= (idx == 5'd3) ? 5'd0 : idx + 5'd1;
								if (idx == 5'd3)
									state <= s_init;
							end
							s_init: begin
								idx <= (idx == 5'd3) ? 5'd0 : idx + 5'd1;
								if (idx == 5'd3) begin
									init_done <= 1'b1;
									state <= s_idle;
								end
							end
							s_addr1: state <= s_line1;
							s_line1: begin
								idx <= idx + 5'd1;
								if (idx == 5'(line_len - 1))
									state <= s_addr2;
							end
							s_addr2: state <= s_line2;
							default: begin
								idx <= idx + 5'd1; // wraps to 0 after the last char
								if (idx == 5'(msg_len - 1))
									state <= display_enable ? s_addr1 : s_idle;
							end
						endcase
					end
				end
			endcase
		end
	end

endmodule

// File: lcd_axi_regs.sv
`timescale 1ns/1ps

module lcd_axi_regs (
	input  logic        clk,
	input  logic        reset,
	input  logic [7:0]  awaddr,
	input  logic        awvalid,
	output logic        awready,
	input  logic [31:0] wdata,
	input  logic [3:0]  wstrb,
	input  logic        wvalid,
	output logic        wready,
	output logic [1:0]  bresp,
	output logic        bvalid,
	input  logic        bready,
	input  logic [7:0]  araddr,
	input  logic        arvalid,
	output logic        arready,
	output logic [31:0] rdata,
	output logic [1:0]  rresp,
	output logic        rvalid,
	input  logic        rready,
	input  logic        init_done,
	input  logic [7:0]  rd_data_a,
	output logic        buf_we,
	output logic [4:0]  buf_waddr,
	output logic [7:0]  buf_wdata,
	output logic [4:0]  rd_addr_a,
	output logic        display_enable
);
	import lcd_pkg::*;

	localparam logic [1:0] resp_okay = 2'b00;
	localparam logic [1:0] resp_slverr = 2'b10;

	logic aw_held;
	logic w_held;
	logic [7:0] awaddr_q;
	logic [31:0] wdata_q;
	logic [3:0] wstrb_q;
	logic aw_hs;
	logic w_hs;
	logic do_write;
	logic [7:0] wr_addr;
	logic [31:0] wr_data;
	logic [3:0] wr_strb;
	logic wr_char;
	logic wr_ctrl;
	logic ctrl_en;
	logic [31:0] rd_word;
	logic [1:0] rd_resp;

	// each channel may arrive alone, hold it until its partner shows up
	assign awready = ~aw_held & ~bvalid;
	assign wready = ~w_held & ~bvalid;
	assign arready = ~rvalid;
	assign aw_hs = awvalid & awready;
	assign w_hs = wvalid & wready;

	assign wr_addr = aw_held ? awaddr_q : awaddr;
	assign wr_data = w_held ? wdata_q : wdata;
	assign wr_strb = w_held ? wstrb_q : wstrb;
	assign do_write = (aw_held | aw_hs) & (w_held | w_hs);

	assign wr_char = (wr_addr[7:5] == addr_char_base[7:5]);
	assign wr_ctrl = (wr_addr == addr_ctrl);

	assign buf_we = do_write & wr_char & wr_strb[0]; // lane 0 only
	assign buf_waddr = wr_addr[4:0];
	assign buf_wdata = wr_data[7:0];
	assign rd_addr_a = araddr[4:0];
	assign display_enable = ctrl_en;

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			aw_held <= 1'b0;
			w_held <= 1'b0;
			bvalid <= 1'b0;
			ctrl_en <= 1'b0;
		end else begin
			if (do_write) begin
				aw_held <= 1'b0;
				w_held <= 1'b0;
				bvalid <= 1'b1;
				if (wr_ctrl && wr_strb[0])
					ctrl_en <= wr_data[0];
			end else begin
				if (aw_hs)
					aw_held <= 1'b1;
				if (w_hs)
					w_held <= 1'b1;
				if (bvalid && bready)
					bvalid <= 1'b0;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (aw_hs)
			awaddr_q <= awaddr;
		if (w_hs) begin
			wdata_q <= wdata;
			wstrb_q <= wstrb;
		end
		if (do_write)
			bresp <= (wr_char || wr_ctrl) ? resp_okay : resp_slverr;
	end

	always_comb begin
		rd_word = '0;
		rd_resp = resp_okay;
		if (araddr[7:5] == addr_char_base[7:5])
			rd_word = {24'd0, rd_data_a};
		else if (araddr == addr_ctrl)
			rd_word = {31'd0, ctrl_en};
		else if (araddr == addr_status)
			rd_word = {31'd0, init_done};
		else
			rd_resp = resp_slverr;
	end

	always_ff @(posedge clk or posedge reset) begin
		if (reset)
			rvalid <= 1'b0;
		else if (arvalid && arready)
			rvalid <= 1'b1;
		else if (rvalid && rready)
			rvalid <= 1'b0;
	end

	always_ff @(posedge clk) begin
		if (arvalid && arready) begin
			rdata <= rd_word;
			rresp <= rd_resp;
		end
	end

endmodule

// File: lcd_top.sv
`timescale 1ns/1ps

module lcd_top #(
	parameter int unsigned powerup_cycles = 100,
	parameter int unsigned setup_cycles = 2,
	parameter int unsigned en_cycles = 4,
	parameter int unsigned nibble_gap = 2,
	parameter int unsigned cmd_wait = 10,
	parameter int unsigned clear_wait = 40
) (
	input  logic        clk,
	input  logic        reset,
	input  logic [7:0]  awaddr,
	input  logic        awvalid,
	output logic        awready,
	input  logic [31:0] wdata,
	input  logic [3:0]  wstrb,
	input  logic        wvalid,
	output logic        wready,
	output logic [1:0]  bresp,
	output logic        bvalid,
	input  logic        bready,
	input  logic [7:0]  araddr,
	input  logic        arvalid,
	output logic        arready,
	output logic [31:0] rdata,
	output logic [1:0]  rresp,
	output logic        rvalid,
	input  logic        rready,
	output logic        lcd_en,
	output logic        lcd_rs,
	output logic [3:0]  lcd_d
);

	logic buf_we;
	logic [4:0] buf_waddr;
	logic [7:0] buf_wdata;
	logic [4:0] rd_addr_a;
	logic [7:0] rd_data_a;
	logic [4:0] rd_addr_b;
	logic [7:0] rd_data_b;
	logic display_enable;
	logic init_done;
	logic tx_start;
	logic [7:0] tx_byte;
	logic tx_rs;
	logic tx_nibble_only;
	logic tx_done;

	lcd_axi_regs i_axi_regs (
		.clk(clk), .reset(reset),
		.awaddr(awaddr), .awvalid(awvalid), .awready(awready),
		.wdata(wdata), .wstrb(wstrb), .wvalid(wvalid), .wready(wready),
		.bresp(bresp), .bvalid(bvalid), .bready(bready),
		.araddr(araddr), .arvalid(arvalid), .arready(arready),
		.rdata(rdata), .rresp(rresp), .rvalid(rvalid), .rready(rready),
		.init_done(init_done), .rd_data_a(rd_data_a),
		.buf_we(buf_we), .buf_waddr(buf_waddr), .buf_wdata(buf_wdata),
		.rd_addr_a(rd_addr_a), .display_enable(display_enable)
	);

	lcd_msg_ram i_msg_ram (
		.clk(clk), .reset(reset),
		.we(buf_we), .waddr(buf_waddr), .wdata(buf_wdata),
		.raddr_a(rd_addr_a), .rdata_a(rd_data_a),
		.raddr_b(rd_addr_b), .rdata_b(rd_data_b)
	);

	lcd_control #(.powerup_cycles(powerup_cycles)) i_control (
		.clk(clk), .reset(reset),
		.display_enable(display_enable), .tx_done(tx_done), .rd_data_b(rd_data_b),
		.rd_addr_b(rd_addr_b), .tx_start(tx_start), .tx_byte(tx_byte),
		.tx_rs(tx_rs), .tx_nibble_only(tx_nibble_only), .init_done(init_done)
	);

	lcd_nibble_tx #(
		.setup_cycles(setup_cycles), .en_cycles(en_cycles), .nibble_gap(nibble_gap),
		.cmd_wait(cmd_wait), .clear_wait(clear_wait)
	) i_nibble_tx (
		.clk(clk), .reset(reset),
		.start(tx_start), .byte_in(tx_byte), .rs(tx_rs), .nibble_only(tx_nibble_only),
		.lcd_en(lcd_en), .lcd_rs(lcd_rs), .lcd_d(lcd_d), .done(tx_done)
	);

endmodule

// File: lcd_chk.sv
`timescale 1ns/1ps

module lcd_chk (
	input logic        clk,
	input logic        reset,
	input logic        lcd_en,
	input logic        lcd_rs,
	input logic [3:0]  lcd_d,
	input logic        awvalid,
	input logic        awready,
	input logic [7:0]  awaddr,
	input logic        wvalid,
	input logic        wready,
	input logic [31:0] wdata,
	input logic        arvalid,
	input logic        arready,
	input logic [7:0]  araddr,
	input logic        bvalid,
	input logic        bready,
	input logic [1:0]  bresp,
	input logic        rvalid,
	input logic        rready,
	input logic [31:0] rdata,
	input logic [1:0]  rresp
);

	// display samples on the falling enable, so the pins hold for the whole pulse
	assert property (@(posedge clk) disable iff (reset)
		(lcd_en || $past(lcd_en)) |-> $stable({lcd_rs, lcd_d}))
		else $error("lcd_d or lcd_rs changed while lcd_en was high");

	assert property (@(posedge clk) disable iff (reset)
		awvalid && !awready |=> awvalid && $stable(awaddr))
		else $error("awvalid dropped or awaddr changed before the beat was taken");

	assert property (@(posedge clk) disable iff (reset)
		wvalid && !wready |=> wvalid && $stable(wdata))
		else $error("wvalid dropped or wdata changed before the beat was taken");

	assert property (@(posedge clk) disable iff (reset)
		arvalid && !arready |=> arvalid && $stable(araddr))
		else $error("arvalid dropped or araddr changed before the beat was taken");

	assert property (@(posedge clk) disable iff (reset)
		bvalid && !bready |=> bvalid && $stable(bresp))
		else $error("write response dropped or changed before bready");

	assert property (@(posedge clk) disable iff (reset)
		rvalid && !rready |=> rvalid && $stable({rdata, rresp}))
		else $error("read response dropped or changed before rready");

endmodule

bind lcd_top lcd_chk i_chk (
	.clk(clk), .reset(reset), .lcd_en(lcd_en), .lcd_rs(lcd_rs), .lcd_d(lcd_d),
	.awvalid(awvalid), .awready(awready), .awaddr(awaddr),
	.wvalid(wvalid), .wready(wready), .wdata(wdata),
	.arvalid(arvalid), .arready(arready), .araddr(araddr),
	.bvalid(bvalid), .bready(bready), .bresp(bresp),
	.rvalid(rvalid), .rready(rready), .rdata(rdata), .rresp(rresp)
);

// File: lcd_tb.sv
`timescale 1ns/1ps

module lcd_tb;

	localparam int unsigned powerup_cycles = 20;
	localparam int unsigned setup_cycles = 2;
	localparam int unsigned en_cycles = 3;
	localparam int unsigned nibble_gap = 2;
	localparam int unsigned cmd_wait = 6;
	localparam int unsigned clear_wait = 16;

	// a full byte followed by the clear settle time is the longest transfer
	localparam int unsigned worst_xfer = 2 * (setup_cycles + en_cycles) + nibble_gap
		+ clear_wait + 4;
	localparam int unsigned max_frames = 8; // a frame check can span two refreshes
	localparam int unsigned limit_cycles = powerup_cycles
		+ (8 + 34 * max_frames) * worst_xfer + 2000;

	logic clk;
	logic reset;
	logic [7:0] awaddr;
	logic awvalid;
	logic awready;
	logic [31:0] wdata;
	logic [3:0] wstrb;
	logic wvalid;
	logic wready;
	logic [1:0] bresp;
	logic bvalid;
	logic bready;
	logic [7:0] araddr;
	logic arvalid;
	logic arready;
	logic [31:0] rdata;
	logic [1:0] rresp;
	logic rvalid;
	logic rready;
	logic lcd_en;
	logic lcd_rs;
	logic [3:0] lcd_d;

	logic [8:0] pin_log [1024]; // {rs, byte} with wake nibbles in the low half
	logic [9:0] pin_wr = '0;
	logic [9:0] pin_rd = '0;
	int en_falls = 0;
	int wake_left = 4;
	logic have_hi = 1'b0;
	logic [3:0] hi_nib = '0;
	logic en_q = 1'b0;
	logic [127:0] exp_line [2];

	lcd_top #(
		.powerup_cycles(powerup_cycles), .setup_cycles(setup_cycles),
		.en_cycles(en_cycles), .nibble_gap(nibble_gap),
		.cmd_wait(cmd_wait), .clear_wait(clear_wait)
	) i_lcd_top (
		.clk(clk), .reset(reset),
		.awaddr(awaddr), .awvalid(awvalid), .awready(awready),
		.wdata(wdata), .wstrb(wstrb), .wvalid(wvalid), .wready(wready),
		.bresp(bresp), .bvalid(bvalid), .bready(bready),
		.araddr(araddr), .arvalid(arvalid), .arready(arready),
		.rdata(rdata), .rresp(rresp), .rvalid(rvalid), .rready(rready),
		.lcd_en(lcd_en), .lcd_rs(lcd_rs), .lcd_d(lcd_d)
	);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	initial begin
		repeat (limit_cycles) @(posedge clk);
		$display("timeout: test sequence still running after %0d clock cycles", limit_cycles);
		$display("CHECKS FAILED");
		$fatal(1, "watchdog expired");
	end

	// the display latches on the falling enable
	always @(negedge clk) begin
		if (en_q && !lcd_en) begin
			en_falls = en_falls + 1;
			if (wake_left > 0) begin
				pin_log[pin_wr] = {lcd_rs, 4'h0, lcd_d};
				pin_wr = pin_wr + 10'd1;
				wake_left = wake_left - 1;
			end else if (!have_hi) begin
				hi_nib = lcd_d;
				have_hi = 1'b1;
			end else begin
				pin_log[pin_wr] = {lcd_rs, hi_nib, lcd_d};
				pin_wr = pin_wr + 10'd1;
				have_hi = 1'b0;
			end
		end
		en_q = lcd_en;
	end

	task automatic stop_run(input string why);
		$display("%s", why);
		$display("CHECKS FAILED");
		$fatal(1, "test stopped");
	endtask

	task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
		if (got !== exp) begin
			$display("error at %0t ns: %s is 'h%0h, expected 'h%0h", $time, name, got, exp);
			stop_run("value mismatch");
		end
	endtask

	task automatic skip_line(input int fd);
		int c;
		c = $fgetc(fd);
		while (c != 10 && c != -1)
			c = $fgetc(fd);
	endtask

	task automatic axi_write(input logic [7:0] addr, input logic [31:0] data,
			input logic [3:0] strb, input logic [1:0] resp, input int stall);
		logic [1:0] held;
		int n;
		@(posedge clk);
		#1;
		awaddr = addr;
		wdata = data;
		wstrb = strb;
		awvalid = 1'b1;
		wvalid = 1'b1;
		bready = (stall == 0);
		do @(negedge clk); while (!(awready && wready));
		@(posedge clk);
		#1;
		awvalid = 1'b0;
		wvalid = 1'b0;
		do @(negedge clk); while (!bvalid);
		held = bresp;
		for (n = 0; n < stall; n++) begin
			@(negedge clk);
			check("bvalid", 32'(bvalid), 32'd1);
			check("bresp", 32'(bresp), 32'(held));
			check("awready", 32'(awready), 32'd0);
			check("wready", 32'(wready), 32'd0);
		end
		if (stall > 0) begin
			@(posedge clk);
			#1 bready = 1'b1;
		end
		@(posedge clk);
		#1 bready = 1'b0;
		check("bresp", 32'(held), 32'(resp));
	endtask

	task automatic axi_read(input logic [7:0] addr, input logic [31:0] data,
			input logic [1:0] resp, input int stall);
		logic [31:0] held_data;
		logic [1:0] held_resp;
		int n;
		@(posedge clk);
		#1;
		araddr = addr;
		arvalid = 1'b1;
		rready = (stall == 0);
		do @(negedge clk); while (!arready);
		@(posedge clk);
		#1 arvalid = 1'b0;
		do @(negedge clk); while (!rvalid);
		held_data = rdata;
		held_resp = rresp;
		for (n = 0; n < stall; n++) begin
			@(negedge clk);
			check("rvalid", 32'(rvalid), 32'd1);
			check("rdata", rdata, held_data);
			check("rresp", 32'(rresp), 32'(held_resp));
			check("arready", 32'(arready), 32'd0);
		end
		if (stall > 0) begin
			@(posedge clk);
			#1 rready = 1'b1;
		end
		@(posedge clk);
		#1 rready = 1'b0;
		check("rdata", held_data, data);
		check("rresp", 32'(held_resp), 32'(resp));
	endtask

	task automatic next_pin_item(output logic [8:0] item);
		while (pin_rd == pin_wr)
			@(posedge clk);
		item = pin_log[pin_rd];
		pin_rd = pin_rd + 10'd1;
	endtask

	task automatic expect_quiet(input int cycles);
		int start;
		check("unread lcd bytes", 32'(pin_wr - pin_rd), 32'd0);
		start = en_falls;
		repeat (cycles) @(posedge clk);
		check("lcd_en pulses", 32'(en_falls - start), 32'd0);
	endtask

	task automatic check_frame();
		logic [8:0] item;
		logic [127:0] bits;
		int i;
		pin_rd = pin_wr; // older traffic may predate the last writes
		do next_pin_item(item); while (item != 9'h080);
		bits = exp_line[0];
		for (i = 0; i < 32; i++) begin
			if (i == 16) begin
				next_pin_item(item);
				check("line 2 address", 32'(item), 32'h0c0);
				bits = exp_line[1];
			end
			next_pin_item(item);
			check("lcd_rs", 32'(item[8]), 32'd1);
			check($sformatf("char %0d", i), 32'(item[7:0]), 32'(bits[127:120]));
			bits = bits << 8;
		end
	endtask

	initial begin
		int fd;
		int rc;
		int num;
		logic [7:0] op;
		logic [7:0] addr;
		logic [31:0] data;
		logic [3:0] strb;
		logic [1:0] resp;
		logic rs;
		logic ln;
		logic [127:0] line_bits;
		reset = 1'b1;
		awaddr = '0;
		awvalid = 1'b0;
		wdata = '0;
		wstrb = '0;
		wvalid = 1'b0;
		bready = 1'b0;
		araddr = '0;
		arvalid = 1'b0;
		rready = 1'b0;
		exp_line[0] = {16{8'h20}};
		exp_line[1] = {16{8'h20}};
		fd = $fopen("lcd_vectors.txt", "r");
		if (fd == 0)
			stop_run("cannot open lcd_vectors.txt");
		repeat (3) @(posedge clk);
		#1 reset = 1'b0;
		while ($fscanf(fd, " %c", op) == 1) begin
			case (op)
				"#": skip_line(fd);
				"W": begin
					rc = $fscanf(fd, "%h %h %h %h %h", addr, data, strb, resp, num);
					if (rc != 5)
						stop_run("malformed write record in lcd_vectors.txt");
					else
						axi_write(addr, data, strb, resp, num);
				end
				"R": begin
					rc = $fscanf(fd, "%h %h %h %h", addr, data, resp, num);
					if (rc != 4)
						stop_run("malformed read record in lcd_vectors.txt");
					else
						axi_read(addr, data, resp, num);
				end
				"P": begin
					rc = $fscanf(fd, "%h %h", rs, addr);
					next_pin_item(line_bits[8:0]);
					check("lcd pin item", 32'(line_bits[8:0]), 32'({rs, addr}));
				end
				"S": begin
					rc = $fscanf(fd, "%h", num);
					expect_quiet(num);
				end
				"L": begin
					rc = $fscanf(fd, "%h %h", ln, line_bits);
					exp_line[ln] = line_bits;
				end
				"F": check_frame();
				default: stop_run($sformatf("unknown record type %c in lcd_vectors.txt", op));
			endcase
		end
		$fclose(fd);
		$display("ALL CHECKS PASSED");
		$finish;
	end

endmodule

// File: lcd_vectors.txt
# W addr wdata wstrb bresp stall | R addr rdata rresp stall | P rs byte | S quiet cycles
# L line chars (32 hex digits) | F check next full frame | all numbers hex
R 84 00000000 0 0
P 0 03
P 0 03
P 0 03
P 0 02
P 0 28
P 0 06
P 0 0c
P 0 01
S 40
R 84 00000001 0 0
W 00 00000048 1 0 0
W 01 00000049 1 0 3
W 00 0000005a 0 0 0
W 10 0000004f 1 0 0
W 1f 0000004b 1 0 0
W 40 00000041 1 2 0
W 84 00000001 1 2 0
W 9c 0000005a 1 2 2
R 00 00000048 0 0
R 01 00000049 0 4
R 02 00000020 0 0
R 40 00000000 2 0
R 9c 00000000 2 3
S 20
W 80 00000001 1 0 0
R 80 00000001 0 0
L 0 48492020202020202020202020202020
L 1 4f20202020202020202020202020204b
F
W 05 00000021 1 0 0
L 0 48492020202120202020202020202020
F

// File: verilog.f
lcd_pkg.sv
lcd_msg_ram.sv
lcd_nibble_tx.sv
lcd_control.sv
lcd_axi_regs.sv
lcd_top.sv
lcd_chk.sv
lcd_tb.sv

// File: run_sim.sh
#!/bin/bash
# build the testbench with Verilator and run it from the project root
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -j 0 --top-module lcd_tb -f verilog.f -o lcd_sim
out=$(./obj_dir/lcd_sim 2>&1) || true
echo "$out"
if grep -q "ALL CHECKS PASSED" <<< "$out"; then
	exit 0
fi
echo "simulation did not pass"
exit 1
